/* Bender.yml */
package:
  name: read_addr_sequencer

sources:
  - addr_seq_pkg.sv
  - loop_counter.sv
  - loop_nest.sv
  - addr_calc.sv
  - sequencer_ctrl.sv
  - read_addr_sequencer.sv
  - target: simulation
    files:
      - read_addr_sequencer_assertions.sv
      - tb_read_addr_sequencer.sv

/* addr_calc.sv */
// Activation and weight read addresses from base and loop indices
// Purely combinational; flush beats read the base addresses

`timescale 1ns/1ps

module addr_calc import addr_seq_pkg::*; (
    input  addr_t act_base,
    input  addr_t wgt_base,
    input  chn_t  num_chn,
    input  idx_t  num_grp,
    input  chn_t  chn_idx,
    input  idx_t  grp_idx,
    input  idx_t  ifm_idx,
    input  idx_t  flt_idx,
    input  logic  flush,
    output addr_t act_addr,
    output addr_t wgt_addr
);

    addr_t tile_stride;
    addr_t inner_off;
    addr_t act_off;
    addr_t wgt_off;

    // One tile spans all channels of all groups
    assign tile_stride = addr_t'(num_chn) * addr_t'(num_grp);

    // Group and channel part is common to both streams
    assign inner_off = addr_t'(num_chn) * addr_t'(grp_idx) + addr_t'(chn_idx);

    // Arithmetic wraps at ADDR_WIDTH
    assign act_off = tile_stride * addr_t'(ifm_idx) + inner_off;
    assign wgt_off = tile_stride * addr_t'(flt_idx) + inner_off;

    assign act_addr = flush ? act_base : act_base + act_off;
    assign wgt_addr = flush ? wgt_base : wgt_base + wgt_off;

endmodule

/* addr_seq_pkg.sv */
// Shared definitions for the read-address sequencer
// Bus widths, array geometry, vector types and the run states

package addr_seq_pkg;

    // ======================================================================
    // Widths
    // ======================================================================
    localparam int ADDR_WIDTH = 16;
    localparam int IDX_WIDTH  = 16;
    localparam int CHN_WIDTH  = 10;

    // ======================================================================
    // Array geometry
    // ======================================================================
    // PE rows in one bank
    localparam int NUM_ROW    = 16;
    // Banks along one side of the square bank arrangement
    localparam int SIDE_BANKS = 2;

    // Wide enough for the longest flush, one less than the largest edge
    localparam int FLUSH_WIDTH = $clog2(2 * NUM_ROW * SIDE_BANKS);

    // ======================================================================
    // Types
    // ======================================================================
    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [IDX_WIDTH-1:0]   idx_t;
    typedef logic [CHN_WIDTH-1:0]   chn_t;
    typedef logic [FLUSH_WIDTH-1:0] flush_cnt_t;

    // Mode 0 is the small square array, any other mode doubles the edge
    typedef logic [1:0] mode_t;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        FLUSH
    } seq_state_e;

endpackage

/* compile.f */
addr_seq_pkg.sv
loop_counter.sv
loop_nest.sv
addr_calc.sv
sequencer_ctrl.sv
read_addr_sequencer.sv
read_addr_sequencer_assertions.sv
tb_read_addr_sequencer.sv

/* loop_counter.sv */
// Wrapping index counter for one loop level
// Synchronous clear, increment and a last-value flag

`timescale 1ns/1ps

module loop_counter import addr_seq_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic clear,
    input  logic inc,
    input  idx_t max_count,
    output idx_t count,
    output logic last
);

    assign last = (count == max_count);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (inc) begin
            // Wrap after the final index
            if (last) begin
                count <= '0;
            end else begin
                count <= count + idx_t'(1);
            end
        end
    end

endmodule

/* loop_nest.sv */
// Four-level loop nest over channel, group, filter tile and input-map tile
// Channel innermost, then group; tile order selected by loop_order
// Raises nest_last on the beat at the final point of the nest

`timescale 1ns/1ps

module loop_nest import addr_seq_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic clear,
    input  logic beat,
    input  logic loop_order,
    input  chn_t num_chn,
    input  idx_t num_grp,
    input  idx_t num_til_ifm,
    input  idx_t num_til_flt,
    output chn_t chn_idx,
    output idx_t grp_idx,
    output idx_t ifm_idx,
    output idx_t flt_idx,
    output logic nest_last
);

    idx_t chn_max;
    idx_t grp_max;
    idx_t ifm_max;
    idx_t flt_max;
    idx_t chn_count;
    logic chn_last;
    logic grp_last;
    logic ifm_last;
    logic flt_last;
    logic inc_grp;
    logic grp_wrap;
    logic inc_ifm;
    logic inc_flt;

    // Counts are 1 or more, so the last index is count minus one
    assign chn_max = idx_t'(num_chn) - idx_t'(1);
    assign grp_max = num_grp - idx_t'(1);
    assign ifm_max = num_til_ifm - idx_t'(1);
    assign flt_max = num_til_flt - idx_t'(1);

    assign inc_grp  = beat & chn_last;
    assign grp_wrap = inc_grp & grp_last;

    always_comb begin
        if (loop_order == 1'b0) begin
            // Filter tile inside input-map tile
            inc_flt = grp_wrap;
            inc_ifm = grp_wrap & flt_last;
        end else begin
            inc_ifm = grp_wrap;
            inc_flt = grp_wrap & ifm_last;
        end
    end

    assign nest_last = beat & chn_last & grp_last & ifm_last & flt_last;

    // ======================================================================
    // Counters
    // ======================================================================
    loop_counter u_chn_cnt (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .inc       (beat),
        .max_count (chn_max),
        .count     (chn_count),
        .last      (chn_last)
    );

    assign chn_idx = chn_t'(chn_count);

    loop_counter u_grp_cnt (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .inc       (inc_grp),
        .max_count (grp_max),
        .count     (grp_idx),
        .last      (grp_last)
    );

    loop_counter u_ifm_cnt (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .inc       (inc_ifm),
        .max_count (ifm_max),
        .count     (ifm_idx),
        .last      (ifm_last)
    );

    loop_counter u_flt_cnt (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .inc       (inc_flt),
        .max_count (flt_max),
        .count     (flt_idx),
        .last      (flt_last)
    );

endmodule

/* read_addr_sequencer.sv */
// Read-address sequencer top level
// Control, loop nest and address calculation wired together

`timescale 1ns/1ps

module read_addr_sequencer import addr_seq_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  soft_clear,
    input  logic  cfg_valid,
    output logic  cfg_ready,
    input  addr_t act_base,
    input  addr_t wgt_base,
    input  chn_t  num_chn,
    input  idx_t  num_grp,
    input  idx_t  num_til_ifm,
    input  idx_t  num_til_flt,
    input  logic  loop_order,
    input  mode_t mode,
    output addr_t act_addr,
    output logic  act_addr_valid,
    input  logic  act_addr_ready,
    output addr_t wgt_addr,
    output logic  wgt_addr_valid,
    input  logic  wgt_addr_ready,
    output logic  flush
);

    addr_t cfg_act_base;
    addr_t cfg_wgt_base;
    chn_t  cfg_num_chn;
    idx_t  cfg_num_grp;
    idx_t  cfg_num_til_ifm;
    idx_t  cfg_num_til_flt;
    logic  cfg_loop_order;
    logic  beat;
    logic  nest_clear;
    logic  nest_last;
    chn_t  chn_idx;
    idx_t  grp_idx;
    idx_t  ifm_idx;
    idx_t  flt_idx;

    sequencer_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .soft_clear      (soft_clear),
        .cfg_valid       (cfg_valid),
        .cfg_ready       (cfg_ready),
        .act_base        (act_base),
        .wgt_base        (wgt_base),
        .num_chn         (num_chn),
        .num_grp         (num_grp),
        .num_til_ifm     (num_til_ifm),
        .num_til_flt     (num_til_flt),
        .loop_order      (loop_order),
        .mode            (mode),
        .act_addr_ready  (act_addr_ready),
        .wgt_addr_ready  (wgt_addr_ready),
        .act_addr_valid  (act_addr_valid),
        .wgt_addr_valid  (wgt_addr_valid),
        .flush           (flush),
        .nest_last       (nest_last),
        .beat            (beat),
        .nest_clear      (nest_clear),
        .cfg_act_base    (cfg_act_base),
        .cfg_wgt_base    (cfg_wgt_base),
        .cfg_num_chn     (cfg_num_chn),
        .cfg_num_grp     (cfg_num_grp),
        .cfg_num_til_ifm (cfg_num_til_ifm),
        .cfg_num_til_flt (cfg_num_til_flt),
        .cfg_loop_order  (cfg_loop_order)
    );

    loop_nest u_nest (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (nest_clear),
        .beat        (beat),
        .loop_order  (cfg_loop_order),
        .num_chn     (cfg_num_chn),
        .num_grp     (cfg_num_grp),
        .num_til_ifm (cfg_num_til_ifm),
        .num_til_flt (cfg_num_til_flt),
        .chn_idx     (chn_idx),
        .grp_idx     (grp_idx),
        .ifm_idx     (ifm_idx),
        .flt_idx     (flt_idx),
        .nest_last   (nest_last)
    );

    addr_calc u_addr (
        .act_base (cfg_act_base),
        .wgt_base (cfg_wgt_base),
        .num_chn  (cfg_num_chn),
        .num_grp  (cfg_num_grp),
        .chn_idx  (chn_idx),
        .grp_idx  (grp_idx),
        .ifm_idx  (ifm_idx),
        .flt_idx  (flt_idx),
        .flush    (flush),
        .act_addr (act_addr),
        .wgt_addr (wgt_addr)
    );

endmodule

/* read_addr_sequencer_assertions.sv */
// Protocol assertions on the sequencer's top-level ports
// Cross-coupled valids and no address traffic while idle

`timescale 1ns/1ps

module read_addr_sequencer_assertions (
    input logic clk,
    input logic rst_n,
    input logic cfg_ready,
    input logic act_addr_valid,
    input logic act_addr_ready,
    input logic wgt_addr_valid,
    input logic wgt_addr_ready
);

    act_valid_needs_wgt_ready: assert property (
        @(posedge clk) disable iff (!rst_n) act_addr_valid |-> wgt_addr_ready
    ) else $error("act_addr_valid high while wgt_addr_ready low");

    wgt_valid_needs_act_ready: assert property (
        @(posedge clk) disable iff (!rst_n) wgt_addr_valid |-> act_addr_ready
    ) else $error("wgt_addr_valid high while act_addr_ready low");

    // Idle means no address on either stream
    no_valid_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) cfg_ready |-> !(act_addr_valid || wgt_addr_valid)
    ) else $error("address valid high while cfg_ready high");

endmodule

bind read_addr_sequencer read_addr_sequencer_assertions u_port_checks (
    .clk            (clk),
    .rst_n          (rst_n),
    .cfg_ready      (cfg_ready),
    .act_addr_valid (act_addr_valid),
    .act_addr_ready (act_addr_ready),
    .wgt_addr_valid (wgt_addr_valid),
    .wgt_addr_ready (wgt_addr_ready)
);

/* sequencer_ctrl.sv */
// Run control for the read-address sequencer
// Config register, IDLE/ISSUE/FLUSH FSM, flush counter and joint handshake

`timescale 1ns/1ps

module sequencer_ctrl import addr_seq_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       soft_clear,
    input  logic       cfg_valid,
    output logic       cfg_ready,
    input  addr_t      act_base,
    input  addr_t      wgt_base,
    input  chn_t       num_chn,
    input  idx_t       num_grp,
    input  idx_t       num_til_ifm,
    input  idx_t       num_til_flt,
    input  logic       loop_order,
    input  mode_t      mode,
    input  logic       act_addr_ready,
    input  logic       wgt_addr_ready,
    output logic       act_addr_valid,
    output logic       wgt_addr_valid,
    output logic       flush,
    input  logic       nest_last,
    output logic       beat,
    output logic       nest_clear,
    output addr_t      cfg_act_base,
    output addr_t      cfg_wgt_base,
    output chn_t       cfg_num_chn,
    output idx_t       cfg_num_grp,
    output idx_t       cfg_num_til_ifm,
    output idx_t       cfg_num_til_flt,
    output logic       cfg_loop_order
);

    seq_state_e state_q;
    seq_state_e state_d;
    mode_t      cfg_mode;
    flush_cnt_t flush_cnt;
    flush_cnt_t flush_len;
    logic       busy;
    logic       xfer;

    assign cfg_ready  = (state_q == IDLE);
    assign busy       = (state_q != IDLE);
    assign flush      = (state_q == FLUSH);
    assign nest_clear = (state_q == IDLE) | soft_clear;

    // Each valid waits only on the other stream's ready
    assign act_addr_valid = busy & wgt_addr_ready;
    assign wgt_addr_valid = busy & act_addr_ready;
    assign xfer           = busy & act_addr_ready & wgt_addr_ready;
    assign beat           = xfer & (state_q == ISSUE);

    // Array edge minus one drain beats
    assign flush_len = (cfg_mode == mode_t'(0)) ?
                       flush_cnt_t'(NUM_ROW * SIDE_BANKS - 1) :
                       flush_cnt_t'(2 * NUM_ROW * SIDE_BANKS - 1);

    // ======================================================================
    // Configuration register
    // ======================================================================
    always_ff @(posedge clk) begin
        if (cfg_valid && cfg_ready) begin
            cfg_act_base    <= act_base;
            cfg_wgt_base    <= wgt_base;
            cfg_num_chn     <= num_chn;
            cfg_num_grp     <= num_grp;
            cfg_num_til_ifm <= num_til_ifm;
            cfg_num_til_flt <= num_til_flt;
            cfg_loop_order  <= loop_order;
            cfg_mode        <= mode;
        end
    end

    // ======================================================================
    // FSM
    // ======================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cfg_valid) begin
                    state_d = ISSUE;
                end
            end
            ISSUE: begin
                if (nest_last) begin
                    state_d = FLUSH;
                end
            end
            FLUSH: begin
                if (xfer && flush_cnt == flush_cnt_t'(1)) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
        // Abort wins over everything
        if (soft_clear) begin
            state_d = IDLE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            flush_cnt <= '0;
        end else begin
            state_q <= state_d;
            if (soft_clear) begin
                flush_cnt <= '0;
            end else if (nest_last) begin
                flush_cnt <= flush_len;
            end else if (flush && xfer) begin
                flush_cnt <= flush_cnt - flush_cnt_t'(1);
            end
        end
    end

endmodule

/* tb_read_addr_sequencer.sv */
// Testbench for the read-address sequencer
// Clock generator, stimulus, reference model, beat checker and timeout

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

endmodule

module tb_read_addr_sequencer import addr_seq_pkg::*; ();

    localparam int RUN_M0 = 36 + 31;
    localparam int RUN_M1 = 36 + 63;
    // Two plain runs, one under back-pressure, one aborted run and its restart
    localparam int TOTAL_BEATS    = 4 * RUN_M0 + RUN_M1;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_BEATS + 200;

    logic   clk;
    logic   rst_n;
    logic   soft_clear;
    logic   cfg_valid;
    logic   cfg_ready;
    addr_t  act_base;
    addr_t  wgt_base;
    chn_t   num_chn;
    idx_t   num_grp;
    idx_t   num_til_ifm;
    idx_t   num_til_flt;
    logic   loop_order;
    mode_t  mode;
    addr_t  act_addr;
    logic   act_addr_valid;
    logic   act_addr_ready;
    addr_t  wgt_addr;
    logic   wgt_addr_valid;
    logic   wgt_addr_ready;
    logic   flush;
    integer seed      = 32'habb9_1088;
    logic   bp_on     = 1'b0;
    int     beat_cnt  = 0;
    int     cycle_cnt = 0;
    logic   end_due   = 1'b0;

    tb_clock_gen u_clk_gen (
        .clk (clk)
    );

    read_addr_sequencer dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .soft_clear     (soft_clear),
        .cfg_valid      (cfg_valid),
        .cfg_ready      (cfg_ready),
        .act_base       (act_base),
        .wgt_base       (wgt_base),
        .num_chn        (num_chn),
        .num_grp        (num_grp),
        .num_til_ifm    (num_til_ifm),
        .num_til_flt    (num_til_flt),
        .loop_order     (loop_order),
        .mode           (mode),
        .act_addr       (act_addr),
        .act_addr_valid (act_addr_valid),
        .act_addr_ready (act_addr_ready),
        .wgt_addr       (wgt_addr),
        .wgt_addr_valid (wgt_addr_valid),
        .wgt_addr_ready (wgt_addr_ready),
        .flush          (flush)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    // ======================================================================
    // Reference model
    // ======================================================================
    // Expected address pair and flush flag for beat k of a run
    function automatic void expected_beat(
        input  int    k,
        input  int    act_b,
        input  int    wgt_b,
        input  int    n_chn,
        input  int    n_grp,
        input  int    n_ifm,
        input  int    n_flt,
        input  logic  order,
        output addr_t act,
        output addr_t wgt,
        output logic  fl
    );
        int chn;
        int grp;
        int outer;
        int ifm;
        int flt;
        chn   = k % n_chn;
        grp   = (k / n_chn) % n_grp;
        outer = k / (n_chn * n_grp);
        if (order == 1'b0) begin
            flt = outer % n_flt;
            ifm = outer / n_flt;
        end else begin
            ifm = outer % n_ifm;
            flt = outer / n_ifm;
        end
        fl = (k >= n_chn * n_grp * n_ifm * n_flt);
        if (fl) begin
            act = addr_t'(act_b);
            wgt = addr_t'(wgt_b);
        end else begin
            act = addr_t'(act_b + n_chn * n_grp * ifm + n_chn * grp + chn);
            wgt = addr_t'(wgt_b + n_chn * n_grp * flt + n_chn * grp + chn);
        end
    endfunction

    // Issue beats plus edge minus one flush beats
    function automatic int run_length(
        input int n_chn,
        input int n_grp,
        input int n_ifm,
        input int n_flt,
        input int md
    );
        int edge_len;
        edge_len = (md == 0) ? 32 : 64;
        return n_chn * n_grp * n_ifm * n_flt + edge_len - 1;
    endfunction

    // ======================================================================
    // Beat checker
    // ======================================================================
    always @(posedge clk) begin : compare_beats
        addr_t exp_act;
        addr_t exp_wgt;
        logic  exp_flush;
        int    total;
        total = run_length(num_chn, num_grp, num_til_ifm, num_til_flt, mode);
        if (rst_n) begin
            if (end_due) begin
                assert (cfg_ready)
                    else fail_run("cfg_ready did not rise in the cycle after the last flush beat");
            end
            end_due = 1'b0;
            if (cfg_valid && cfg_ready) begin
                beat_cnt = 0;
            end
            if (cfg_ready) begin
                assert (!act_addr_valid && !wgt_addr_valid && !flush)
                    else fail_run("Address valid or flush was high while the sequencer was idle");
            end else begin
                assert (beat_cnt < total)
                    else fail_run("Sequencer kept issuing beats after the run should have ended");
                expected_beat(beat_cnt, act_base, wgt_base, num_chn, num_grp, num_til_ifm,
                              num_til_flt, loop_order, exp_act, exp_wgt, exp_flush);
                assert (act_addr_valid == wgt_addr_ready)
                    else fail_run($sformatf("ERR act_addr_valid expected 0x%h actual 0x%h",
                                            wgt_addr_ready, act_addr_valid));
                assert (wgt_addr_valid == act_addr_ready)
                    else fail_run($sformatf("ERR wgt_addr_valid expected 0x%h actual 0x%h",
                                            act_addr_ready, wgt_addr_valid));
                assert (act_addr == exp_act)
                    else fail_run($sformatf("ERR act_addr expected 0x%h actual 0x%h",
                                            exp_act, act_addr));
                assert (wgt_addr == exp_wgt)
                    else fail_run($sformatf("ERR wgt_addr expected 0x%h actual 0x%h",
                                            exp_wgt, wgt_addr));
                assert (flush == exp_flush)
                    else fail_run($sformatf("ERR flush expected 0x%h actual 0x%h",
                                            exp_flush, flush));
                if (act_addr_valid && act_addr_ready) begin
                    end_due  = (beat_cnt == total - 1);
                    beat_cnt = beat_cnt + 1;
                end
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycle_cnt = cycle_cnt + 1;
        assert (cycle_cnt < TIMEOUT_CYCLES)
            else fail_run("The run timed out before all tests had finished");
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    always @(negedge clk) begin : drive_ready
        logic [31:0] r;
        if (bp_on) begin
            r = $random(seed);
            act_addr_ready = (r[1:0] != 2'b00);
            wgt_addr_ready = (r[3:2] != 2'b00);
        end else begin
            act_addr_ready = 1'b1;
            wgt_addr_ready = 1'b1;
        end
    end

    task automatic start_run(
        input addr_t ab,
        input addr_t wb,
        input chn_t  c,
        input idx_t  g,
        input idx_t  i,
        input idx_t  f,
        input logic  order,
        input mode_t m
    );
        @(negedge clk);
        assert (cfg_ready)
            else fail_run("A configuration was offered while the sequencer was busy");
        act_base    = ab;
        wgt_base    = wb;
        num_chn     = c;
        num_grp     = g;
        num_til_ifm = i;
        num_til_flt = f;
        loop_order  = order;
        mode        = m;
        cfg_valid   = 1'b1;
        @(negedge clk);
        cfg_valid = 1'b0;
        assert (!cfg_ready)
            else fail_run("Sequencer did not start after the configuration handshake");
    endtask

    task automatic wait_run_end();
        int expected;
        while (!cfg_ready) begin
            @(negedge clk);
        end
        expected = run_length(num_chn, num_grp, num_til_ifm, num_til_flt, mode);
        assert (beat_cnt == expected)
            else fail_run($sformatf("ERR beat_cnt expected 0x%h actual 0x%h",
                                    expected, beat_cnt));
    endtask

    initial begin
        rst_n          = 1'b0;
        soft_clear     = 1'b0;
        cfg_valid      = 1'b0;
        act_base       = '0;
        wgt_base       = '0;
        num_chn        = chn_t'(1);
        num_grp        = idx_t'(1);
        num_til_ifm    = idx_t'(1);
        num_til_flt    = idx_t'(1);
        loop_order     = 1'b0;
        mode           = '0;
        act_addr_ready = 1'b1;
        wgt_addr_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        assert (cfg_ready && !act_addr_valid && !wgt_addr_valid && !flush)
            else fail_run("Outputs were not idle after reset");

        // Filter tile inside input-map tile, 32-wide array
        start_run(16'h0100, 16'h8000, 10'd3, 16'd2, 16'd2, 16'd3, 1'b0, 2'd0);
        wait_run_end();

        // Reversed tile order, 64-wide array
        start_run(16'h1200, 16'h9000, 10'd3, 16'd2, 16'd2, 16'd3, 1'b1, 2'd1);
        wait_run_end();

        // Same sequence as the first run, with random back-pressure
        bp_on = 1'b1;
        start_run(16'h0100, 16'h8000, 10'd3, 16'd2, 16'd2, 16'd3, 1'b0, 2'd0);
        wait_run_end();
        bp_on = 1'b0;

        // Abort part way through the loop nest
        start_run(16'h2000, 16'ha000, 10'd3, 16'd2, 16'd2, 16'd3, 1'b0, 2'd0);
        while (beat_cnt < 20) begin
            @(negedge clk);
        end
        soft_clear = 1'b1;
        @(negedge clk);
        soft_clear = 1'b0;
        assert (cfg_ready && !act_addr_valid && !wgt_addr_valid && !flush)
            else fail_run("Sequencer did not return to idle after soft_clear");

        // Restart from index zero, bases near the top so the addresses wrap
        start_run(16'hfff0, 16'h7ff8, 10'd3, 16'd2, 16'd2, 16'd3, 1'b1, 2'd0);
        wait_run_end();

        $display("Everything OK");
        $finish;
    end

endmodule
